//--- source/sys16_defines.svh
`ifndef SYS16_DEFINES_SVH
`define SYS16_DEFINES_SVH

// Bus widths
`define SYS16_ADDR_W    23          // Word address, bits 23 to 1
`define SYS16_DATA_W    16

// Region codes, top address bits [23:22] and page bits [18:16]
`define SYS16_TOP_ROM   2'd0        // 00-03, any page
`define SYS16_TOP_VRAM  2'd1
`define SYS16_PAGE_VRAM 3'd0        // 40
`define SYS16_TOP_CHAR  2'd1
`define SYS16_PAGE_CHAR 3'd1        // 41
`define SYS16_TOP_OBJ   2'd1
`define SYS16_PAGE_OBJ  3'd4        // 44
`define SYS16_TOP_PAL   2'd2
`define SYS16_PAGE_PAL  3'd4        // 84
`define SYS16_TOP_RAM   2'd3
`define SYS16_PAGE_RAM  3'd7        // c7

`define SYS16_VBL_LINE  9'd223      // VBLANK interrupt line
`define SYS16_OPEN_BUS  16'hffff    // Nothing selected

`endif

//--- source/sys16_pkg.sv
`default_nettype none
`include "sys16_defines.svh"

package sys16_pkg;

    // One word on the 68000 data bus
    typedef logic [`SYS16_DATA_W-1:0] bus_word_t;

    // Memory region hit by a CPU address
    typedef enum logic [2:0] {
        region_none,    // Unmapped, also I/O and watchdog
        region_rom,
        region_vram,
        region_char,
        region_obj,
        region_pal,
        region_ram
    } sys16_region_e;

endpackage

`default_nettype wire

//--- source/sys16_map_decode.sv
`timescale 1ns/100ps
`default_nettype none
`include "sys16_defines.svh"

module sys16_map_decode (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     as_n,
    input  wire [`SYS16_ADDR_W:1]   addr,
    output logic                    rom_cs,
    output logic                    char_cs,
    output logic                    objram_cs,
    output logic                    pal_cs,
    output logic                    pre_vram_cs,   // Before cpu_cen qualification
    output logic                    pre_ram_cs
);
    import sys16_pkg::*;

    logic [1:0]    top;
    logic [2:0]    page;
    sys16_region_e region;

    assign top  = addr[23:22];
    assign page = addr[18:16];

    // System 16A memory map
    always_comb begin
        if (top == `SYS16_TOP_ROM) begin
            region = region_rom;
        end else if (top == `SYS16_TOP_VRAM && page == `SYS16_PAGE_VRAM) begin
            region = region_vram;
        end else if (top == `SYS16_TOP_CHAR && page == `SYS16_PAGE_CHAR) begin
            region = region_char;
        end else if (top == `SYS16_TOP_OBJ && page == `SYS16_PAGE_OBJ) begin
            region = region_obj;
        end else if (top == `SYS16_TOP_PAL && page == `SYS16_PAGE_PAL) begin
            region = region_pal;
        end else if (top == `SYS16_TOP_RAM && page == `SYS16_PAGE_RAM) begin
            region = region_ram;
        end else begin
            region = region_none;  // I/O and watchdog land here too
        end
    end

    // One-hot selects, held only while the address strobe is low
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rom_cs      <= 1'b0;
            char_cs     <= 1'b0;
            objram_cs   <= 1'b0;
            pal_cs      <= 1'b0;
            pre_vram_cs <= 1'b0;
            pre_ram_cs  <= 1'b0;
        end else begin
            rom_cs      <= !as_n && region == region_rom;
            char_cs     <= !as_n && region == region_char;
            objram_cs   <= !as_n && region == region_obj;
            pal_cs      <= !as_n && region == region_pal;
            pre_vram_cs <= !as_n && region == region_vram;
            pre_ram_cs  <= !as_n && region == region_ram;
        end
    end

endmodule

`default_nettype wire

//--- source/sys16_bus_wait.sv
`timescale 1ns/100ps
`default_nettype none

module sys16_bus_wait (
    input  wire     clk,
    input  wire     rst,
    input  wire     cpu_cen,
    input  wire     cpu_cenb,
    input  wire     as_n,
    input  wire     uds_wn,
    input  wire     lds_wn,
    input  wire     rom_cs,
    input  wire     char_cs,
    input  wire     objram_cs,
    input  wire     pal_cs,
    input  wire     pre_vram_cs,
    input  wire     pre_ram_cs,
    input  wire     rom_ok,
    input  wire     ram_ok,
    output logic    ram_cs,
    output logic    vram_cs,
    output logic    dtack_n
);

    logic [1:0] wn_last;     // Write strobes seen on the previous clk
    logic       wn_stable;
    logic [1:0] pre_cs;      // {ram, vram}
    logic [1:0] cs;
    logic       bus_cs;
    logic       bus_busy;

    assign wn_stable = wn_last == {uds_wn, lds_wn};
    assign pre_cs    = {pre_ram_cs, pre_vram_cs};
    assign {ram_cs, vram_cs} = cs;

    // Any mapped region that acknowledges the CPU
    assign bus_cs = rom_cs | char_cs | objram_cs | pal_cs | pre_vram_cs | pre_ram_cs;

    // Slow sources still fetching
    assign bus_busy = (rom_cs & ~rom_ok) | ((pre_ram_cs | pre_vram_cs) & ~ram_ok);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wn_last <= 2'b11;
        end else begin
            wn_last <= {uds_wn, lds_wn};
        end
    end

    // RAM requests start on a cpu_cen edge with settled strobes,
    // then hold until the pre-select drops
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cs <= 2'b00;
        end else begin
            cs <= pre_cs & (cs | {2{cpu_cen & wn_stable}});
        end
    end

    // DTACK on the cpu_cenb phase, released at the end of AS
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dtack_n <= 1'b1;
        end else if (as_n) begin
            dtack_n <= 1'b1;
        end else if (cpu_cenb && bus_cs && !bus_busy) begin
            dtack_n <= 1'b0;      // Unmapped accesses never get here
        end
    end

endmodule

`default_nettype wire

//--- source/sys16_rd_mux.sv
`timescale 1ns/100ps
`default_nettype none
`include "sys16_defines.svh"

module sys16_rd_mux (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         ram_cs,
    input  wire                         vram_cs,
    input  wire                         rom_cs,
    input  wire                         char_cs,
    input  wire                         pal_cs,
    input  wire                         objram_cs,
    input  wire sys16_pkg::bus_word_t   ram_data,    // Shared by RAM and VRAM
    input  wire sys16_pkg::bus_word_t   rom_data,
    input  wire sys16_pkg::bus_word_t   char_dout,
    input  wire sys16_pkg::bus_word_t   pal_dout,
    input  wire sys16_pkg::bus_word_t   obj_dout,
    output sys16_pkg::bus_word_t        cpu_din
);

    // Fixed priority, RAM and VRAM first
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cpu_din <= `SYS16_OPEN_BUS;
        end else if (ram_cs || vram_cs) begin
            cpu_din <= ram_data;
        end else if (rom_cs) begin
            cpu_din <= rom_data;
        end else if (char_cs) begin
            cpu_din <= char_dout;
        end else if (pal_cs) begin
            cpu_din <= pal_dout;
        end else if (objram_cs) begin
            cpu_din <= obj_dout;
        end else begin
            cpu_din <= `SYS16_OPEN_BUS;    // Open bus
        end
    end

endmodule

`default_nettype wire

//--- source/sys16_vblank_irq.sv
`timescale 1ns/100ps
`default_nettype none
`include "sys16_defines.svh"

module sys16_vblank_irq (
    input  wire         clk,
    input  wire         rst,
    input  wire         hstart,
    input  wire [8:0]   vdump,
    input  wire         as_n,
    input  wire [2:0]   fc,
    output logic        ipl2_n      // Level 4, VBLANK
);

    logic hstart_last;
    logic hstart_rise;
    logic int_ack;

    assign hstart_rise = hstart & ~hstart_last;
    assign int_ack     = &fc & ~as_n;   // CPU space cycle

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hstart_last <= 1'b0;
            ipl2_n      <= 1'b1;
        end else begin
            hstart_last <= hstart;
            // Acknowledge has priority over a new request
            if (int_ack) begin
                ipl2_n <= 1'b1;
            end else if (hstart_rise && vdump == `SYS16_VBL_LINE) begin
                ipl2_n <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/sys16_main.sv
`timescale 1ns/100ps
`default_nettype none
`include "sys16_defines.svh"

module sys16_main (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         cpu_cen,
    input  wire                         cpu_cenb,
    // CPU bus
    input  wire [`SYS16_ADDR_W:1]       addr,
    input  wire                         as_n,
    input  wire                         uds_n,
    input  wire                         lds_n,
    input  wire                         rnw,
    input  wire [2:0]                   fc,
    input  wire sys16_pkg::bus_word_t   cpu_dout,   // Write data, routed to memories outside
    output sys16_pkg::bus_word_t        cpu_din,
    output wire                         dtack_n,
    output wire                         ipl2_n,
    output wire                         uds_wn,
    output wire                         lds_wn,
    output wire [12:1]                  cpu_addr,
    output wire [17:1]                  rom_addr,
    // Memory side
    output wire                         rom_cs,
    output wire                         char_cs,
    output wire                         objram_cs,
    output wire                         pal_cs,
    output wire                         ram_cs,
    output wire                         vram_cs,
    input  wire sys16_pkg::bus_word_t   rom_data,
    input  wire                         rom_ok,
    input  wire sys16_pkg::bus_word_t   ram_data,
    input  wire                         ram_ok,
    input  wire sys16_pkg::bus_word_t   char_dout,
    input  wire sys16_pkg::bus_word_t   pal_dout,
    input  wire sys16_pkg::bus_word_t   obj_dout,
    // Video timing
    input  wire [8:0]                   vdump,
    input  wire                         hstart
);

    wire pre_vram_cs;
    wire pre_ram_cs;

    assign uds_wn   = rnw | uds_n;
    assign lds_wn   = rnw | lds_n;
    assign cpu_addr = addr[12:1];
    assign rom_addr = addr[17:1];

    sys16_map_decode u_decode (
        .clk         (clk),
        .rst         (rst),
        .as_n        (as_n),
        .addr        (addr),
        .rom_cs      (rom_cs),
        .char_cs     (char_cs),
        .objram_cs   (objram_cs),
        .pal_cs      (pal_cs),
        .pre_vram_cs (pre_vram_cs),
        .pre_ram_cs  (pre_ram_cs)
    );

    sys16_bus_wait u_wait (
        .clk         (clk),
        .rst         (rst),
        .cpu_cen     (cpu_cen),
        .cpu_cenb    (cpu_cenb),
        .as_n        (as_n),
        .uds_wn      (uds_wn),
        .lds_wn      (lds_wn),
        .rom_cs      (rom_cs),
        .char_cs     (char_cs),
        .objram_cs   (objram_cs),
        .pal_cs      (pal_cs),
        .pre_vram_cs (pre_vram_cs),
        .pre_ram_cs  (pre_ram_cs),
        .rom_ok      (rom_ok),
        .ram_ok      (ram_ok),
        .ram_cs      (ram_cs),
        .vram_cs     (vram_cs),
        .dtack_n     (dtack_n)
    );

    sys16_rd_mux u_rd_mux (
        .clk         (clk),
        .rst         (rst),
        .ram_cs      (ram_cs),
        .vram_cs     (vram_cs),
        .rom_cs      (rom_cs),
        .char_cs     (char_cs),
        .pal_cs      (pal_cs),
        .objram_cs   (objram_cs),
        .ram_data    (ram_data),
        .rom_data    (rom_data),
        .char_dout   (char_dout),
        .pal_dout    (pal_dout),
        .obj_dout    (obj_dout),
        .cpu_din     (cpu_din)
    );

    sys16_vblank_irq u_irq (
        .clk         (clk),
        .rst         (rst),
        .hstart      (hstart),
        .vdump       (vdump),
        .as_n        (as_n),
        .fc          (fc),
        .ipl2_n      (ipl2_n)
    );

endmodule

`default_nettype wire

//--- bench/sys16_main_checker.sv
`timescale 1ns/100ps
`default_nettype none

module sys16_main_checker (
    input  wire                         clk,
    input  wire                         rst,
    input  wire [23:1]                  addr,
    input  wire                         as_n,
    input  wire                         uds_n,
    input  wire                         lds_n,
    input  wire                         rnw,
    input  wire [2:0]                   fc,
    input  wire                         cpu_cenb,
    input  wire                         uds_wn,
    input  wire                         lds_wn,
    input  wire [12:1]                  cpu_addr,
    input  wire [17:1]                  rom_addr,
    input  wire                         rom_cs,
    input  wire                         char_cs,
    input  wire                         objram_cs,
    input  wire                         pal_cs,
    input  wire                         ram_cs,
    input  wire                         vram_cs,
    input  wire                         rom_ok,
    input  wire                         ram_ok,
    input  wire                         dtack_n,
    input  wire                         ipl2_n,
    input  wire                         hstart,
    input  wire [8:0]                   vdump,
    input  wire sys16_pkg::bus_word_t   cpu_din,
    output logic [31:0]                 error_count
);
    import sys16_pkg::*;

    // Samples from the previous falling edge
    logic          p_valid;
    logic [23:1]   p_addr;
    logic          p_as_n;
    logic [2:0]    p_fc;
    logic          p_cenb;
    logic [1:0]    p_wn;
    logic [1:0]    pp_wn;          // write strobes one edge earlier
    logic [1:0]    p_ramsel;       // {ram_cs, vram_cs}
    logic [5:0]    p_sel;          // all selects
    logic          p_rom_ok;
    logic          p_ram_ok;
    logic          p_dtack_n;
    logic [1:0]    h_hist;         // hstart, last two samples
    logic [8:0]    p_vdump;
    logic          exp_ipl2_n;
    sys16_region_e p_region;       // Region behind the pre-selects

    function automatic sys16_region_e region_of(input logic [23:1] a);
        if (a[23:22] == 2'b00) begin
            return region_rom;
        end
        case ({a[23:22], a[18:16]})
            5'b01_000: return region_vram;
            5'b01_001: return region_char;
            5'b01_100: return region_obj;
            5'b10_100: return region_pal;
            5'b11_111: return region_ram;
            default:   return region_none;
        endcase
    endfunction

    task automatic report(input string msg);
        $display("error at %0t: %s", $time, msg);
        error_count = error_count + 1;
    endtask

    initial error_count = 0;

    always @(negedge clk) begin
        sys16_region_e r;
        logic          any_sel;
        if (rst) begin
            if (rom_cs || char_cs || objram_cs || pal_cs || ram_cs || vram_cs)
                report("chip select high in reset");
            if (dtack_n !== 1'b1 || ipl2_n !== 1'b1)
                report("dtack_n or ipl2_n low in reset");
            if (cpu_din !== 16'hffff)
                report($sformatf("cpu_din %h in reset, expected ffff", cpu_din));
            p_valid    = 1'b0;
            p_region   = region_none;
            h_hist     = 2'b00;
            exp_ipl2_n = 1'b1;
        end else begin
            // A write strobe is low only for a write with its byte strobe low
            if (uds_wn !== !(!rnw && !uds_n) || lds_wn !== !(!rnw && !lds_n))
                report("write strobes do not follow rnw and the data strobes");
            if (cpu_addr !== addr[12:1] || rom_addr !== addr[17:1])
                report("cpu_addr or rom_addr is not a slice of addr");
            r = p_as_n ? region_none : region_of(p_addr);
            if (p_valid) begin
                if (rom_cs !== (r == region_rom) || char_cs !== (r == region_char) ||
                    objram_cs !== (r == region_obj) || pal_cs !== (r == region_pal))
                    report($sformatf("wrong chip select for %h", {p_addr, 1'b0}));
                if ((ram_cs && p_region != region_ram) ||
                    (vram_cs && p_region != region_vram))
                    report($sformatf("RAM select out of place for %h", {p_addr, 1'b0}));
                if (p_as_n && dtack_n !== 1'b1)
                    report("dtack_n low after the address strobe ended");
                if (p_sel == 6'b0 && cpu_din !== 16'hffff)
                    report($sformatf("cpu_din %h with nothing selected, expected ffff",
                                     cpu_din));
                // Falling DTACK needs cenb and a ready, mapped source
                if (p_dtack_n && !dtack_n) begin
                    any_sel = |p_sel;
                    if (!p_cenb || !any_sel)
                        report("dtack_n fell without cpu_cenb or a select");
                    if ((p_sel[5] && !p_rom_ok) || (|p_ramsel && !p_ram_ok))
                        report("dtack_n fell while the source was not ready");
                end
                if ((ram_cs && !p_ramsel[1]) || (vram_cs && !p_ramsel[0])) begin
                    if (p_wn !== pp_wn)
                        report("RAM select rose with changing write strobes");
                end
                // Ack first, then the line 223 edge
                if (&p_fc && !p_as_n)
                    exp_ipl2_n = 1'b1;
                else if (h_hist == 2'b10 && p_vdump == 9'd223)
                    exp_ipl2_n = 1'b0;
                if (ipl2_n !== exp_ipl2_n)
                    report($sformatf("ipl2_n %b, expected %b", ipl2_n, exp_ipl2_n));
            end
            p_valid  = 1'b1;
            p_region = r;
            h_hist   = {hstart, h_hist[1]};
        end
        p_addr    = addr;
        p_as_n    = as_n;
        p_fc      = fc;
        p_cenb    = cpu_cenb;
        pp_wn     = p_wn;
        p_wn      = {uds_wn, lds_wn};
        p_ramsel  = {ram_cs, vram_cs};
        p_sel     = {rom_cs, char_cs, objram_cs, pal_cs, ram_cs, vram_cs};
        p_rom_ok  = rom_ok;
        p_ram_ok  = ram_ok;
        p_dtack_n = dtack_n;
        p_vdump   = vdump;
    end

endmodule

`default_nettype wire

//--- bench/sys16_main_tb.sv
`timescale 1ns/100ps
`default_nettype none
`include "sys16_defines.svh"

module sys16_main_tb;
    import sys16_pkg::*;

    logic          clk = 1'b0;
    logic          rst;
    logic          cpu_cen;
    logic          cpu_cenb;
    logic [1:0]    phase;
    logic [23:1]   addr;
    logic          as_n;
    logic          uds_n;
    logic          lds_n;
    logic          rnw;
    logic [2:0]    fc;
    bus_word_t     cpu_dout;
    bus_word_t     cpu_din;
    wire           dtack_n;
    wire           ipl2_n;
    wire           uds_wn;
    wire           lds_wn;
    wire [12:1]    cpu_addr;
    wire [17:1]    rom_addr;
    wire           rom_cs;
    wire           char_cs;
    wire           objram_cs;
    wire           pal_cs;
    wire           ram_cs;
    wire           vram_cs;
    bus_word_t     rom_data;
    bus_word_t     ram_data;
    bus_word_t     char_dout;
    bus_word_t     pal_dout;
    bus_word_t     obj_dout;
    logic          rom_ok;
    logic          ram_ok;
    logic [8:0]    vdump;
    logic          hstart;
    integer        seed;
    integer        rom_dly;
    integer        ram_dly;
    integer        rom_cnt;
    integer        ram_cnt;
    integer        tb_errors;
    logic          aborted;
    wire [31:0]    chk_errors;

    always #4 clk = ~clk;

    // Each memory returns a region key over the low word address bits
    assign rom_data  = {4'h1, addr[12:1]};
    assign ram_data  = {vram_cs ? 4'h3 : 4'h2, addr[12:1]};
    assign char_dout = {4'h4, addr[12:1]};
    assign obj_dout  = {4'h5, addr[12:1]};
    assign pal_dout  = {4'h6, addr[12:1]};

    // Clock enables and slow memory ready, driven after the edge
    always @(posedge clk) begin
        #1;
        phase    = phase + 2'd1;
        cpu_cen  = phase == 2'd0;
        cpu_cenb = phase == 2'd2;
        rom_cnt  = rom_cs ? rom_cnt + 1 : 0;
        ram_cnt  = (ram_cs || vram_cs) ? ram_cnt + 1 : 0;
        rom_ok   = rom_cs && rom_cnt > rom_dly;
        ram_ok   = (ram_cs || vram_cs) && ram_cnt > ram_dly;
    end

    sys16_main u_dut (
        .clk(clk), .rst(rst), .cpu_cen(cpu_cen), .cpu_cenb(cpu_cenb),
        .addr(addr), .as_n(as_n), .uds_n(uds_n), .lds_n(lds_n), .rnw(rnw),
        .fc(fc), .cpu_dout(cpu_dout), .cpu_din(cpu_din), .dtack_n(dtack_n),
        .ipl2_n(ipl2_n), .uds_wn(uds_wn), .lds_wn(lds_wn), .cpu_addr(cpu_addr),
        .rom_addr(rom_addr), .rom_cs(rom_cs), .char_cs(char_cs),
        .objram_cs(objram_cs), .pal_cs(pal_cs), .ram_cs(ram_cs), .vram_cs(vram_cs),
        .rom_data(rom_data), .rom_ok(rom_ok), .ram_data(ram_data), .ram_ok(ram_ok),
        .char_dout(char_dout), .pal_dout(pal_dout), .obj_dout(obj_dout),
        .vdump(vdump), .hstart(hstart)
    );

    sys16_main_checker u_checker (
        .clk(clk), .rst(rst), .addr(addr), .as_n(as_n), .uds_n(uds_n), .lds_n(lds_n),
        .rnw(rnw), .fc(fc), .cpu_cenb(cpu_cenb), .uds_wn(uds_wn), .lds_wn(lds_wn),
        .cpu_addr(cpu_addr), .rom_addr(rom_addr),
        .rom_cs(rom_cs), .char_cs(char_cs), .objram_cs(objram_cs), .pal_cs(pal_cs),
        .ram_cs(ram_cs), .vram_cs(vram_cs), .rom_ok(rom_ok), .ram_ok(ram_ok),
        .dtack_n(dtack_n), .ipl2_n(ipl2_n), .hstart(hstart), .vdump(vdump),
        .cpu_din(cpu_din), .error_count(chk_errors)
    );

    task automatic log_mismatch(input string msg);
        $display("error at %0t: %s", $time, msg);
        tb_errors = tb_errors + 1;
    endtask

    function automatic integer delay_from(input string s);
        integer d;
        if (s == "-")
            return {$random(seed)} % 6;    // No delay in the file
        void'($sscanf(s, "%d", d));
        return d;
    endfunction

    // One 68000 bus cycle, ended by DTACK or by the timeout
    task automatic bus_cycle(input logic rd, input logic [23:0] a, input bus_word_t wd,
                             input logic [1:0] be, output logic got, output bus_word_t rdata,
                             output logic [1:0] wn);
        integer n;
        @(posedge clk);
        #1;
        addr     = a[23:1];
        rnw      = rd;
        fc       = 3'd5;
        cpu_dout = wd;
        as_n     = 1'b0;
        if (rd) begin
            uds_n = !be[1];
            lds_n = !be[0];
        end else begin
            // Data strobes follow AS by one clk on a write
            @(posedge clk);
            #1;
            uds_n = !be[1];
            lds_n = !be[0];
        end
        got      = 1'b0;
        n        = 0;
        while (!got && n < 60) begin
            @(negedge clk);
            got   = !dtack_n;
            rdata = cpu_din;
            wn    = {uds_wn, lds_wn};
            n     = n + 1;
        end
        @(posedge clk);
        #1;
        {as_n, uds_n, lds_n, rnw} = 4'b1111;
        n = 0;
        while (dtack_n !== 1'b1 && n < 10) begin
            @(negedge clk);
            n = n + 1;
        end
        if (dtack_n !== 1'b1) begin
            $display("Timeout: dtack_n stayed low after the address strobe ended");
            aborted = 1'b1;
        end
    endtask

    // Hstart pulse on one video line, or an acknowledge cycle
    task automatic video_event(input logic ack, input logic [8:0] line, input logic exp);
        integer n;
        @(posedge clk);
        #1;
        if (ack) begin
            addr = 23'h780000;    // f00000, unmapped
            fc   = 3'd7;
            as_n = 1'b0;
        end else begin
            vdump  = line;
            hstart = 1'b0;
        end
        repeat (2) @(posedge clk);
        #1;
        if (ack) begin
            as_n = 1'b1;
            fc   = 3'd5;
        end else begin
            hstart = 1'b1;
            repeat (2) @(posedge clk);
            #1 hstart = 1'b0;
        end
        n = 0;
        while (ipl2_n !== exp && n < 8) begin
            @(negedge clk);
            n = n + 1;
        end
        repeat (4) @(negedge clk);    // Level must hold
        if (ipl2_n !== exp)
            log_mismatch($sformatf("ipl2_n %b after line %h, expected %b", ipl2_n, line, exp));
    endtask

    initial begin
        integer      fd;
        integer      cnt;
        string       line;
        string       op;
        string       rom_s;
        string       ram_s;
        string       exp_s;
        logic [23:0] a;
        bus_word_t   wd;
        bus_word_t   exp_v;
        bus_word_t   rdata;
        logic [1:0]  be;
        logic [1:0]  wn;
        logic        got;
        seed      = 32'h9430_912b;
        tb_errors = 0;
        aborted   = 1'b0;
        {rom_dly, ram_dly, rom_cnt, ram_cnt} = {4{32'd0}};
        {rst, as_n, uds_n, lds_n, rnw} = 5'b11111;
        {cpu_cen, cpu_cenb, rom_ok, ram_ok, hstart} = 5'b00000;
        phase    = 2'd1;
        addr     = '0;
        fc       = 3'd5;
        cpu_dout = '0;
        vdump    = 9'd0;
        repeat (8) @(posedge clk);
        #1 rst = 1'b0;
        fd = $fopen("bench/sys16_main_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open bench/sys16_main_tests.txt");
            aborted = 1'b1;
        end
        while (!aborted && !$feof(fd)) begin
            if ($fgets(line, fd) == 0 || line.len() < 2 || line.substr(0, 1) == "//")
                continue;
            cnt = $sscanf(line, "%s %h %h %h %s %s %s", op, a, wd, be, rom_s, ram_s, exp_s);
            if (cnt != 7) begin
                $display("Bad line in the test file: %s", line);
                tb_errors = tb_errors + 1;
                continue;
            end
            if (op == "v" || op == "a") begin
                video_event(op == "a", a[8:0], exp_s == "1");
                continue;
            end
            rom_dly = delay_from(rom_s);
            ram_dly = delay_from(ram_s);
            bus_cycle(op == "r", a, wd, be, got, rdata, wn);
            if (exp_s == "nd") begin
                if (got)
                    log_mismatch($sformatf("unmapped %h got dtack", a));
            end else if (!got) begin
                $display("Timeout: no dtack for access to %h", a);
                aborted = 1'b1;
            end else if (op == "r") begin
                void'($sscanf(exp_s, "%h", exp_v));
                if (rdata !== exp_v)
                    log_mismatch($sformatf("read %h gave %h, expected %h", a, rdata, exp_v));
            end else if (wn !== ~be) begin
                log_mismatch($sformatf("write %h strobes %b, expected %b", a, wn, ~be));
            end
        end
        if (fd != 0)
            $fclose(fd);
        repeat (4) @(posedge clk);
        $display("Errors: %0d in bus checks, %0d in the checker", tb_errors, chk_errors);
        if (!aborted && tb_errors == 0 && chk_errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- sys16_bus.f
+incdir+source
source/sys16_pkg.sv
source/sys16_map_decode.sv
source/sys16_bus_wait.sv
source/sys16_rd_mux.sv
source/sys16_vblank_irq.sv
source/sys16_main.sv
bench/sys16_main_checker.sv
bench/sys16_main_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary -j 0
TOP       = sys16_main_tb
FILELIST  = sys16_bus.f
LOG       = sim.log

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q -F '*** PASSED ***' $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- bench/sys16_main_tests.txt
// op addr wdata be romdly ramdly expect
// op r read, w write, v video line (addr is vdump), a irq acknowledge
// be is {uds, lds}; a delay of - is random; expect is hex, nd for no dtack, - for none
r 000100 0000 3 0 0 1080
r 000246 0000 3 3 0 1123
r 03fffe 0000 3 6 0 1fff
r 010a20 0000 3 - 0 1510
r 400010 0000 3 0 0 3008
r 400202 0000 3 0 4 3101
r 410044 0000 3 0 0 4022
r 411ffe 0000 3 0 0 4fff
r 440100 0000 3 0 0 5080
r 840020 0000 3 0 0 6010
r c70000 0000 3 0 0 2000
r c70abc 0000 3 0 5 255e
r c7fffe 0000 3 0 - 2fff
// I/O, watchdog and holes in the map
r c40000 0000 3 0 0 nd
r c00000 0000 3 0 0 nd
r 420000 0000 3 0 0 nd
r 800000 0000 3 0 0 nd
w c70010 1234 3 0 0 -
w c70012 00ab 1 0 2 -
w c70014 ab00 2 0 - -
w 400040 5a5a 2 0 - -
w 410000 beef 3 0 0 -
w 840002 0f0f 3 0 0 -
r c70010 0000 3 0 0 2008
// VBLANK interrupt
v 0de 0000 0 0 0 1
v 0df 0000 0 0 0 0
a 000000 0000 0 0 0 1
v 0e0 0000 0 0 0 1
v 0df 0000 0 0 0 0
v 000 0000 0 0 0 0
a 000000 0000 0 0 0 1
r 000002 0000 3 - - 1001
